/* m26_rx.f */
source/m26_rx_pkg.sv
source/m26_rx_ch.sv
source/m26_rx_merge.sv
source/m26_rx_ctrl.sv
source/m26_rx_fifo.sv
source/m26_rx_top.sv
sim/m26_rx_clkgen.sv
sim/m26_rx_assert.sv
sim/m26_rx_tb.sv

/* Bender.yml */
package:
  name: m26_rx

sources:
  # receiver RTL, package first
  - source/m26_rx_pkg.sv
  - source/m26_rx_ch.sv
  - source/m26_rx_merge.sv
  - source/m26_rx_ctrl.sv
  - source/m26_rx_fifo.sv
  - source/m26_rx_top.sv

  # testbench
  - target: simulation
    files:
      - sim/m26_rx_clkgen.sv
      - sim/m26_rx_assert.sv
      - sim/m26_rx_tb.sv

/* sim/m26_rx_tests.txt */
// enable ts_header timestamp len0 len1 frames read_mode(0 drain, 1 stall) lost_count
// every value is hex
1 0 12345678 3 3 2 0 0
1 1 cafe0001 5 5 2 0 0
1 0 00000000 4 4 2 1 18
1 0 00000000 0 0 1 0 0
0 1 00000010 4 4 1 0 0
1 1 a5a50f0f 258 258 1 0 0

/* sim/m26_rx_tb.sv */
// testbench for the m26 receiver with file driven frames checked against a reference queue
`timescale 1ns/1ps

module m26_rx_tb;
    import m26_rx_pkg::*;

    localparam int fields        = 8;
    localparam int max_tests     = 32;
    localparam int settle_cycles = 24;    // longer than any lane pipeline
    localparam int gap_cycles    = 4;

    logic        CLK_RX;
    logic        RST_SYNC;
    logic        restart;
    logic        mkd_rx;
    logic [1:0]  data_rx;
    logic        enable;
    logic        ts_header;
    logic [31:0] timestamp;
    logic        fifo_read;
    rx_word_t    fifo_data;
    logic        fifo_empty;
    logic [7:0]  lost_cnt;
    logic        lost_error;

    logic [31:0] tests_mem [fields*max_tests];
    logic [15:0] lane0_q [$];
    logic [15:0] lane1_q [$];
    rx_word_t    exp_q [$];
    logic [31:0] rng_state;
    logic [31:0] frame_no;
    int          n_tests;
    int          errors;
    int          checks;
    int          words_done;
    int          ref_stored;
    int          ref_lost;
    logic        ref_flag;
    logic        stall_model;
    logic        cur_enable;
    int          cycle_cnt;
    int          timeout_limit = 1000;

    m26_rx_clkgen clkgen0 (
        .restart  (restart),
        .CLK_RX   (CLK_RX),
        .RST_SYNC (RST_SYNC)
    );

    m26_rx_top dut0 (
        .CLK_RX     (CLK_RX),
        .RST_SYNC   (RST_SYNC),
        .mkd_rx     (mkd_rx),
        .data_rx    (data_rx),
        .enable     (enable),
        .ts_header  (ts_header),
        .timestamp  (timestamp),
        .fifo_read  (fifo_read),
        .fifo_data  (fifo_data),
        .fifo_empty (fifo_empty),
        .lost_cnt   (lost_cnt),
        .lost_error (lost_error)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic rx_word_t make_word(input logic lane, input logic start,
                                           input logic [15:0] d);
        rx_word_t w;
        w.header      = rx_header;
        w.plane       = plane_id;
        w.spare       = 1'b0;
        w.lane        = lane;
        w.lost        = 1'b0;
        w.frame_start = start;
        w.data        = d;
        return w;
    endfunction

    task automatic check_value(input string name, input int got, input int want);
        checks++;
        assert (got == want) else begin
            $display("MISMATCH time %0t %s expected %0d got %0d", $time, name, want, got);
            errors++;
        end
    endtask

    // write control model where the fill level only matters while reads are stalled
    task automatic push_expected(input rx_word_t w);
        if (!cur_enable) return;
        if (stall_model && ref_stored >= fifo_depth) begin
            if (ref_lost < 255) ref_lost++;
            ref_flag = 1'b1;
        end else begin
            w.lost   = ref_flag;
            ref_flag = 1'b0;
            exp_q.push_back(w);
            if (stall_model) ref_stored++;
        end
    endtask

    task automatic build_frame(input logic [15:0] len, input logic [31:0] ts,
                               input logic ts_mode);
        int          n;
        logic [15:0] d0;
        logic [15:0] d1;
        lane0_q.delete();
        lane1_q.delete();
        n = (len > max_data_words) ? max_data_words : len;
        frame_no++;
        lane0_q = {16'h5555, frame_no[31:16], frame_no[15:0], len};
        lane1_q = {16'h5556, frame_no[31:16], frame_no[15:0], len};
        for (int i = 0; i < n; i++) begin
            rng_state = xorshift(rng_state);
            lane0_q.push_back(rng_state[15:0]);
            lane1_q.push_back(rng_state[31:16]);
        end
        lane0_q = {lane0_q, 16'haa50, 16'haa51};
        lane1_q = {lane1_q, 16'haa50, 16'haa51};
        foreach (lane0_q[i]) begin
            d0 = (i == 0 && ts_mode) ? ts[15:0] : lane0_q[i];
            d1 = (i == 0 && ts_mode) ? ts[31:16] : lane1_q[i];
            push_expected(make_word(1'b0, i == 0, d0));    // lane 0 finishes first
            push_expected(make_word(1'b1, i == 0, d1));
        end
    endtask

    task automatic send_frame(input logic [31:0] ts);
        @(posedge CLK_RX);
        mkd_rx    <= 1'b1;
        timestamp <= ts;
        foreach (lane0_q[w]) begin
            for (int b = word_w - 1; b >= 0; b--) begin
                @(posedge CLK_RX);
                mkd_rx  <= 1'b0;
                data_rx <= {lane1_q[w][b], lane0_q[w][b]};
                // live value moves between the lane 0 and lane 1 header words
                if (w == 1 && b == word_w - 5) timestamp <= ~ts;
            end
        end
        @(posedge CLK_RX);
        data_rx <= 2'b00;
        repeat (gap_cycles) @(posedge CLK_RX);
    endtask

    task automatic reset_dut(input logic rd_on);
        @(posedge CLK_RX);
        restart   <= 1'b1;
        fifo_read <= rd_on;
        @(posedge CLK_RX);
        restart <= 1'b0;
        do @(negedge CLK_RX); while (RST_SYNC);
        check_value("fifo_empty", fifo_empty, 1);
        check_value("lost_cnt", lost_cnt, 0);
        check_value("lost_error", lost_error, 0);
    endtask

    task automatic wait_drain();
        while (exp_q.size() > 0) @(posedge CLK_RX);
    endtask

    task automatic run_test(input int idx);
        logic        en;
        logic        ts_mode;
        logic [31:0] ts_base;
        logic [15:0] len0;
        logic [15:0] len1;
        int          n_frames;
        logic        stall;
        int          exp_lost;
        int          err_start;
        en        = tests_mem[idx*fields][0];
        ts_mode   = tests_mem[idx*fields+1][0];
        ts_base   = tests_mem[idx*fields+2];
        len0      = tests_mem[idx*fields+3][15:0];
        len1      = tests_mem[idx*fields+4][15:0];
        n_frames  = tests_mem[idx*fields+5];
        stall     = tests_mem[idx*fields+6][0];
        exp_lost  = tests_mem[idx*fields+7];
        err_start = errors + dut0.assert0.fail_cnt;
        words_done = 0;
        @(posedge CLK_RX);
        enable     <= en;
        ts_header  <= ts_mode;
        cur_enable  = en;
        reset_dut(!stall);
        ref_stored  = 0;
        ref_lost    = 0;
        ref_flag    = 1'b0;
        stall_model = stall;
        assert (len0 == len1) else begin
            $display("test %0d gives the two lanes different lengths", idx);
            errors++;
        end
        for (int f = 0; f < n_frames; f++) begin
            build_frame(len0, ts_base + f, ts_mode);
            send_frame(ts_base + f);
        end
        repeat (settle_cycles) @(posedge CLK_RX);
        if (stall) begin
            @(negedge CLK_RX);
            check_value("lost_cnt", lost_cnt, exp_lost);
            check_value("lost_error", lost_error, exp_lost != 0);
            assert (ref_lost == exp_lost) else begin
                $display("test %0d: model lost %0d words but the test file expects %0d",
                         idx, ref_lost, exp_lost);
                errors++;
            end
            @(posedge CLK_RX);
            fifo_read <= 1'b1;
            wait_drain();
            stall_model = 1'b0;    // one more frame whose first word carries the loss
            build_frame(len0, ts_base + n_frames, ts_mode);
            send_frame(ts_base + n_frames);
        end
        wait_drain();
        repeat (settle_cycles) @(posedge CLK_RX);
        @(negedge CLK_RX);
        check_value("lost_cnt", lost_cnt, exp_lost);
        check_value("fifo_empty", fifo_empty, 1);
        $display("test %0d: %0d words checked, %0d errors", idx, words_done,
                 errors + dut0.assert0.fail_cnt - err_start);
    endtask

    // the head word is taken at the next edge when fifo_read is high
    always @(negedge CLK_RX) begin
        if (fifo_read && !fifo_empty) begin
            checks++;
            assert (exp_q.size() > 0) else begin
                $display("%0t: word %h left the FIFO when none was expected", $time, fifo_data);
                errors++;
            end
            if (exp_q.size() > 0) begin
                assert (fifo_data == exp_q[0]) else begin
                    $display("MISMATCH time %0t fifo_data expected %h got %h",
                             $time, exp_q[0], fifo_data);
                    errors++;
                end
                void'(exp_q.pop_front());
                words_done++;
            end
        end
    end

    always @(posedge CLK_RX) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > timeout_limit) begin
            $display("timeout after %0d cycles, expected words never arrived", cycle_cnt);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        int t_len;
        int t_frames;
        int total;
        restart   = 1'b0;
        mkd_rx    = 1'b0;
        data_rx   = 2'b00;
        enable    = 1'b0;
        ts_header = 1'b0;
        timestamp = '0;
        fifo_read = 1'b0;
        rng_state = 32'hec4c;
        frame_no  = '0;
        errors    = 0;
        checks    = 0;
        cycle_cnt = 0;
        foreach (tests_mem[i]) tests_mem[i] = '1;    // end marker
        $readmemh("sim/m26_rx_tests.txt", tests_mem);
        n_tests = 0;
        while (n_tests < max_tests && tests_mem[n_tests*fields] != '1) n_tests++;
        timeout_limit = 200;
        for (int t = 0; t < n_tests; t++) begin
            t_len    = tests_mem[t*fields+3];
            t_len    = (t_len > max_data_words) ? max_data_words : t_len;
            t_frames = tests_mem[t*fields+5] + tests_mem[t*fields+6];
            timeout_limit += 2 * (t_frames * ((6 + t_len) * word_w + gap_cycles + 2)
                                  + 3 * settle_cycles + 2 * fifo_depth + 40);
        end
        assert (n_tests > 0) else begin
            $display("no test lines were read from the test file");
            errors++;
        end
        for (int t = 0; t < n_tests; t++) run_test(t);
        total = errors + dut0.assert0.fail_cnt;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 n_tests, checks, errors, dut0.assert0.fail_cnt);
        if (total == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* sim/m26_rx_assert.sv */
// bound checks on the receiver top, FIFO write guard, channel reset state and loss flag
`timescale 1ns/1ps

module m26_rx_assert (
    input logic                     CLK_RX,
    input logic                     RST_SYNC,
    input logic                     fifo_write,
    input logic                     fifo_full,
    input logic [7:0]               lost_cnt,
    input logic                     lost_error,
    input m26_rx_pkg::frame_state_t state0,
    input m26_rx_pkg::frame_state_t state1
);
    import m26_rx_pkg::*;

    int unsigned fail_cnt = 0;    // summed into the testbench result

    no_write_when_full: assert property (@(posedge CLK_RX) disable iff (RST_SYNC)
        fifo_write |-> !fifo_full)
    else begin
        $error("fifo_write seen while the FIFO is full");
        fail_cnt++;
    end

    // both lanes back in idle one edge after reset
    idle_after_reset: assert property (@(posedge CLK_RX)
        RST_SYNC |=> (state0 == idle && state1 == idle))
    else begin
        $error("lane state not idle after reset");
        fail_cnt++;
    end

    lost_flag_match: assert property (@(posedge CLK_RX) disable iff (RST_SYNC)
        lost_error == (lost_cnt != 8'd0))
    else begin
        $error("lost_error does not follow lost_cnt");
        fail_cnt++;
    end

endmodule

bind m26_rx_top m26_rx_assert assert0 (
    .CLK_RX     (CLK_RX),
    .RST_SYNC   (RST_SYNC),
    .fifo_write (fifo_write),
    .fifo_full  (fifo_full),
    .lost_cnt   (lost_cnt),
    .lost_error (lost_error),
    .state0     (lane0.state),
    .state1     (lane1.state)
);

/* sim/m26_rx_clkgen.sv */
// testbench clock and reset source, 40 ns clock and a 10 cycle synchronous reset
`timescale 1ns/1ps

module m26_rx_clkgen (
    input  logic restart,
    output logic CLK_RX,
    output logic RST_SYNC
);
    localparam int half_period  = 20;
    localparam int reset_cycles = 10;

    int rst_cnt;

    initial begin
        CLK_RX   = 1'b0;
        RST_SYNC = 1'b1;
        rst_cnt  = 0;
        forever #(half_period) CLK_RX = ~CLK_RX;
    end

    always @(posedge CLK_RX) begin
        if (restart) begin
            RST_SYNC <= 1'b1;
            rst_cnt  <= 0;
        end else if (RST_SYNC) begin
            if (rst_cnt == reset_cycles - 1) begin
                RST_SYNC <= 1'b0;
            end else begin
                rst_cnt <= rst_cnt + 1;
            end
        end
    end

endmodule

/* source/m26_rx_top.sv */
// m26 receiver top, two lane decoders feeding merge, write control and output FIFO
`timescale 1ns/1ps

module m26_rx_top (
    input  logic                 CLK_RX,
    input  logic                 RST_SYNC,
    input  logic                 mkd_rx,
    input  logic [1:0]           data_rx,
    input  logic                 enable,
    input  logic                 ts_header,
    input  logic [31:0]          timestamp,
    input  logic                 fifo_read,
    output m26_rx_pkg::rx_word_t fifo_data,
    output logic                 fifo_empty,
    output logic [7:0]           lost_cnt,
    output logic                 lost_error
);
    import m26_rx_pkg::*;

    logic       word_strobe0;
    logic       word_strobe1;
    lane_word_t lane_word0;
    lane_word_t lane_word1;
    logic       merge_strobe;
    rx_word_t   merge_word;
    logic       fifo_write;
    rx_word_t   fifo_word;
    logic       fifo_full;

    m26_rx_ch #(.lane_delay(0)) lane0 (
        .CLK_RX      (CLK_RX),
        .RST_SYNC    (RST_SYNC),
        .mkd         (mkd_rx),
        .din         (data_rx[0]),
        .word_strobe (word_strobe0),
        .lane_word   (lane_word0)
    );

    // lane 1 lags so the lanes never finish a word together
    m26_rx_ch #(.lane_delay(lane_gap)) lane1 (
        .CLK_RX      (CLK_RX),
        .RST_SYNC    (RST_SYNC),
        .mkd         (mkd_rx),
        .din         (data_rx[1]),
        .word_strobe (word_strobe1),
        .lane_word   (lane_word1)
    );

    m26_rx_merge merge0 (
        .CLK_RX       (CLK_RX),
        .RST_SYNC     (RST_SYNC),
        .ts_header    (ts_header),
        .timestamp    (timestamp),
        .strobe0      (word_strobe0),
        .strobe1      (word_strobe1),
        .word0        (lane_word0),
        .word1        (lane_word1),
        .merge_strobe (merge_strobe),
        .merge_word   (merge_word)
    );

    m26_rx_ctrl ctrl0 (
        .CLK_RX       (CLK_RX),
        .RST_SYNC     (RST_SYNC),
        .enable       (enable),
        .merge_strobe (merge_strobe),
        .merge_word   (merge_word),
        .fifo_full    (fifo_full),
        .fifo_write   (fifo_write),
        .fifo_word    (fifo_word),
        .lost_cnt     (lost_cnt),
        .lost_error   (lost_error)
    );

    m26_rx_fifo fifo0 (
        .CLK_RX   (CLK_RX),
        .RST_SYNC (RST_SYNC),
        .write    (fifo_write),
        .wdata    (fifo_word),
        .read     (fifo_read),
        .rdata    (fifo_data),
        .full     (fifo_full),
        .empty    (fifo_empty)
    );

endmodule

/* source/m26_rx_fifo.sv */
// m26 output FIFO, first-word fall-through buffer for the 32-bit receiver words
`timescale 1ns/1ps

module m26_rx_fifo (
    input  logic                 CLK_RX,
    input  logic                 RST_SYNC,
    input  logic                 write,
    input  m26_rx_pkg::rx_word_t wdata,
    input  logic                 read,
    output m26_rx_pkg::rx_word_t rdata,
    output logic                 full,
    output logic                 empty
);
    import m26_rx_pkg::*;

    rx_word_t           mem [fifo_depth];
    logic [fifo_aw-1:0] wr_ptr;
    logic [fifo_aw-1:0] rd_ptr;
    logic [fifo_aw:0]   count;
    logic               do_write;
    logic               do_read;

    assign full     = (count == (fifo_aw + 1)'(fifo_depth));
    assign empty    = (count == '0);
    assign do_write = write & ~full;
    assign do_read  = read & ~empty;
    assign rdata    = mem[rd_ptr];    // head word shows without a read

    always_ff @(posedge CLK_RX) begin
        if (do_write) mem[wr_ptr] <= wdata;
    end

    always_ff @(posedge CLK_RX) begin
        if (RST_SYNC) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == fifo_aw'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == fifo_aw'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* source/m26_rx_ctrl.sv */
// m26 write control, gates words by enable and keeps track of words lost to a full FIFO
`timescale 1ns/1ps

module m26_rx_ctrl (
    input  logic                 CLK_RX,
    input  logic                 RST_SYNC,
    input  logic                 enable,
    input  logic                 merge_strobe,
    input  m26_rx_pkg::rx_word_t merge_word,
    input  logic                 fifo_full,
    output logic                 fifo_write,
    output m26_rx_pkg::rx_word_t fifo_word,
    output logic [7:0]           lost_cnt,
    output logic                 lost_error
);
    import m26_rx_pkg::*;

    logic word_valid;
    logic word_lost;
    logic lost_flag;

    assign word_valid = enable & merge_strobe;
    assign fifo_write = word_valid & ~fifo_full;
    assign word_lost  = word_valid & fifo_full;
    assign lost_error = (lost_cnt != '0);

    always_comb begin
        fifo_word      = merge_word;
        fifo_word.lost = lost_flag;
    end

    always_ff @(posedge CLK_RX) begin
        if (RST_SYNC) begin
            lost_cnt  <= '0;
            lost_flag <= 1'b0;
        end else begin
            if (word_lost && lost_cnt != '1) lost_cnt <= lost_cnt + 1'b1;    // saturates
            if (word_lost) begin
                lost_flag <= 1'b1;
            end else if (fifo_write) begin
                lost_flag <= 1'b0;
            end
        end
    end

endmodule

/* source/m26_rx_merge.sv */
// m26 lane merge, interleaves both lanes and can put the timestamp into the headers
`timescale 1ns/1ps

module m26_rx_merge (
    input  logic                   CLK_RX,
    input  logic                   RST_SYNC,
    input  logic                   ts_header,
    input  logic [31:0]            timestamp,
    input  logic                   strobe0,
    input  logic                   strobe1,
    input  m26_rx_pkg::lane_word_t word0,
    input  m26_rx_pkg::lane_word_t word1,
    output logic                   merge_strobe,
    output m26_rx_pkg::rx_word_t   merge_word
);
    import m26_rx_pkg::*;

    logic [31:0]       ts_saved;
    lane_word_t        sel_word;
    logic [word_w-1:0] sel_data;

    // lanes are staggered, lane 0 only wins on a collision
    always_comb begin
        sel_word = strobe0 ? word0 : word1;
        sel_data = sel_word.data;
        if (ts_header && sel_word.frame_start) begin
            sel_data = strobe0 ? timestamp[word_w-1:0] : ts_saved[2*word_w-1:word_w];
        end
    end

    always_ff @(posedge CLK_RX) begin
        if (strobe0 && word0.frame_start) ts_saved <= timestamp;    // frame start time
    end

    always_ff @(posedge CLK_RX) begin
        if (RST_SYNC) begin
            merge_strobe <= 1'b0;
        end else begin
            merge_strobe <= strobe0 | strobe1;
        end
    end

    always_ff @(posedge CLK_RX) begin
        merge_word.header      <= rx_header;
        merge_word.plane       <= plane_id;
        merge_word.spare       <= 1'b0;
        merge_word.lane        <= ~strobe0;
        merge_word.lost        <= 1'b0;    // filled in by ctrl
        merge_word.frame_start <= sel_word.frame_start;
        merge_word.data        <= sel_data;
    end

endmodule

/* source/m26_rx_ch.sv */
// m26 lane deserializer, cuts one serial lane into frame words and tracks the frame
`timescale 1ns/1ps

module m26_rx_ch #(
    parameter int lane_delay = 0
) (
    input  logic                   CLK_RX,
    input  logic                   RST_SYNC,
    input  logic                   mkd,
    input  logic                   din,
    output logic                   word_strobe,
    output m26_rx_pkg::lane_word_t lane_word
);
    import m26_rx_pkg::*;

    localparam int bit_cnt_w = $clog2(word_w);

    logic [lane_delay:0]  mkd_pipe;
    logic [lane_delay:0]  din_pipe;
    logic                 mkd_d;
    logic                 din_d;
    logic [word_w-1:0]    shift_reg;
    logic [word_w-1:0]    word_next;
    logic [bit_cnt_w-1:0] bit_cnt;
    logic                 word_done;
    logic [len_w-1:0]     word_cnt;
    logic [len_w-1:0]     len_q;
    logic [len_w-1:0]     len_clamped;
    frame_state_t         state;

    // stage 0 is the input register, the rest is the lane delay
    always_ff @(posedge CLK_RX) begin
        if (RST_SYNC) begin
            mkd_pipe <= '0;
        end else begin
            mkd_pipe[0] <= mkd;
            for (int i = 1; i <= lane_delay; i++) begin
                mkd_pipe[i] <= mkd_pipe[i-1];
            end
        end
    end

    always_ff @(posedge CLK_RX) begin
        din_pipe[0] <= din;
        for (int i = 1; i <= lane_delay; i++) begin
            din_pipe[i] <= din_pipe[i-1];
        end
    end

    assign mkd_d       = mkd_pipe[lane_delay];
    assign din_d       = din_pipe[lane_delay];
    assign word_next   = {shift_reg[word_w-2:0], din_d};    // msb first
    assign word_done   = (state != idle) && !mkd_d && (bit_cnt == bit_cnt_w'(word_w - 1));
    assign len_clamped = (word_next > max_data_words) ? len_w'(max_data_words)
                                                      : word_next[len_w-1:0];

    always_ff @(posedge CLK_RX) begin
        if (RST_SYNC) begin
            state       <= idle;
            bit_cnt     <= '0;
            word_cnt    <= '0;
            word_strobe <= 1'b0;
        end else begin
            word_strobe <= word_done;
            if (mkd_d) begin    // marker restarts the frame, even mid frame
                state    <= header;
                bit_cnt  <= '0;
                word_cnt <= '0;
            end else if (state != idle) begin
                bit_cnt <= word_done ? '0 : bit_cnt + 1'b1;
                if (word_done) begin
                    word_cnt <= word_cnt + 1'b1;
                    case (state)
                        header: begin
                            state    <= frame_cnt;
                            word_cnt <= '0;
                        end
                        frame_cnt: begin
                            if (word_cnt == len_w'(1)) begin
                                state    <= length;
                                word_cnt <= '0;
                            end
                        end
                        length: begin
                            word_cnt <= '0;
                            if (len_clamped == '0) begin
                                state <= trailer;
                            end else begin
                                state <= data;
                            end
                        end
                        data: begin
                            if (word_cnt == len_q - 1'b1) begin
                                state    <= trailer;
                                word_cnt <= '0;
                            end
                        end
                        trailer: begin
                            if (word_cnt == len_w'(1)) state <= idle;
                        end
                        default: state <= idle;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge CLK_RX) begin
        shift_reg <= word_next;
        if (word_done) begin
            lane_word.data        <= word_next;
            lane_word.frame_start <= (state == header);
        end
        if (word_done && state == length) len_q <= len_clamped;
    end

endmodule

/* source/m26_rx_pkg.sv */
// m26 receiver package with word formats, frame states and sizing constants
package m26_rx_pkg;

    // lane word format
    localparam int word_w         = 16;
    localparam int lane_gap       = 4;    // lane 1 lags lane 0 by this many cycles
    localparam int max_data_words = 570;
    localparam int len_w          = $clog2(max_data_words + 1);

    // output buffer
    localparam int fifo_depth = 16;
    localparam int fifo_aw    = $clog2(fifo_depth);

    // constant fields of every output word
    localparam logic [7:0] rx_header = 8'h20;
    localparam logic [3:0] plane_id  = 4'h1;

    typedef enum logic [2:0] {
        idle,
        header,
        frame_cnt,
        length,
        data,
        trailer
    } frame_state_t;

    typedef struct packed {
        logic [word_w-1:0] data;
        logic              frame_start;    // header word of the frame
    } lane_word_t;

    typedef struct packed {
        logic [7:0]        header;
        logic [3:0]        plane;
        logic              spare;
        logic              lane;
        logic              lost;           // words were dropped before this one
        logic              frame_start;
        logic [word_w-1:0] data;
    } rx_word_t;

endpackage
